/* src/rt_pkg.sv */
package rt_pkg;

  localparam int COORD_W  = 8;
  localparam int EDGE_W   = COORD_W + 1;
  localparam int CROSS_W  = 2 * EDGE_W + 1;
  localparam int DOT_W    = 32;
  localparam int TRI_ID_W = 9;
  localparam int THREAD_W = 5;
  localparam int SID_W    = 32;

  typedef logic signed [DOT_W-1:0] dot_t;

  typedef struct packed {
    logic signed [COORD_W-1:0] x;
    logic signed [COORD_W-1:0] y;
    logic signed [COORD_W-1:0] z;
  } vec3_t;

  typedef struct packed {
    logic signed [EDGE_W-1:0] x;
    logic signed [EDGE_W-1:0] y;
    logic signed [EDGE_W-1:0] z;
  } edge3_t;

  typedef struct packed {
    logic signed [CROSS_W-1:0] x;
    logic signed [CROSS_W-1:0] y;
    logic signed [CROSS_W-1:0] z;
  } cross3_t;

  typedef struct packed {
    logic [TRI_ID_W-1:0] tri_id;
    logic [THREAD_W-1:0] thread_id;
    logic [SID_W-1:0]    sid;
  } id_bundle_t;

  typedef struct packed {
    vec3_t      orig;
    vec3_t      dir;
    vec3_t      v0;
    vec3_t      v1;
    vec3_t      v2;
    id_bundle_t ids;
  } ray_tri_t;

  typedef struct packed {
    vec3_t      dir;
    edge3_t     e1;
    edge3_t     e2;
    edge3_t     t;
    id_bundle_t ids;
  } setup_t;

  typedef struct packed {
    dot_t       det;
    dot_t       u_pre;
    id_bundle_t ids;
  } det_res_t;

  typedef struct packed {
    dot_t v_pre;
    dot_t t_pre;
  } q_res_t;

  typedef struct packed {
    dot_t       det;
    dot_t       u_pre;
    dot_t       v_pre;
    dot_t       t_pre;
    id_bundle_t ids;
  } stage3_t;

  typedef struct packed {
    id_bundle_t ids;
    logic       hit;
    dot_t       det;
    dot_t       t_pre;
  } hit_result_t;

  typedef enum logic [1:0] {
    IDLE,
    GOT_DET,
    GOT_Q,
    ACK
  } join_state_t;

  function automatic edge3_t widen3(vec3_t a);
    edge3_t r;
    r.x = EDGE_W'(a.x);
    r.y = EDGE_W'(a.y);
    r.z = EDGE_W'(a.z);
    return r;
  endfunction

  function automatic edge3_t sub3(vec3_t a, vec3_t b);
    edge3_t r;
    r.x = EDGE_W'(a.x) - EDGE_W'(b.x); // one extra bit keeps the difference exact.
    r.y = EDGE_W'(a.y) - EDGE_W'(b.y);
    r.z = EDGE_W'(a.z) - EDGE_W'(b.z);
    return r;
  endfunction

  function automatic cross3_t cross3(edge3_t a, edge3_t b);
    cross3_t r;
    r.x = CROSS_W'(a.y) * CROSS_W'(b.z) - CROSS_W'(a.z) * CROSS_W'(b.y);
    r.y = CROSS_W'(a.z) * CROSS_W'(b.x) - CROSS_W'(a.x) * CROSS_W'(b.z);
    r.z = CROSS_W'(a.x) * CROSS_W'(b.y) - CROSS_W'(a.y) * CROSS_W'(b.x);
    return r;
  endfunction

  function automatic dot_t dot3(edge3_t a, cross3_t b);
    return DOT_W'(a.x) * DOT_W'(b.x) + DOT_W'(a.y) * DOT_W'(b.y) +
           DOT_W'(a.z) * DOT_W'(b.z);
  endfunction

endpackage

/* src/edge_setup.sv */
`timescale 1ns/100ps

module edge_setup (
  input  logic             clk,
  input  logic             rst,
  input  rt_pkg::ray_tri_t in,
  input  logic             in_valid,
  output logic             in_ready,
  output rt_pkg::setup_t   setup,
  output logic             setup_valid,
  input  logic             det_ready,
  input  logic             q_ready
);
  import rt_pkg::*;

  logic drain;
  logic load;

  // the entry leaves only when both paths take it on the same edge.
  assign drain    = setup_valid && det_ready && q_ready;
  assign in_ready = !setup_valid || drain;
  assign load     = in_valid && in_ready;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      setup_valid <= 1'b0;
    end else if (in_ready) begin
      setup_valid <= in_valid;
    end
  end

  // edges and the offset vector are all taken relative to v0.
  always_ff @(posedge clk) begin
    if (load) begin
      setup.dir <= in.dir;
      setup.e1  <= sub3(in.v1, in.v0);
      setup.e2  <= sub3(in.v2, in.v0);
      setup.t   <= sub3(in.orig, in.v0);
      setup.ids <= in.ids;
    end
  end

endmodule

/* src/det_path.sv */
`timescale 1ns/100ps

module det_path (
  input  logic             clk,
  input  logic             rst,
  input  rt_pkg::setup_t   setup,
  input  logic             setup_valid,
  output logic             setup_ready,
  output rt_pkg::det_res_t det_res,
  output logic             det_valid,
  input  logic             det_ack
);
  import rt_pkg::*;

  logic       a_valid;
  logic       a_ready;
  logic       b_ready;
  cross3_t    a_p;
  edge3_t     a_e1;
  edge3_t     a_t;
  id_bundle_t a_ids;

  // stage B empties only when the join releases it.
  assign b_ready     = !det_valid || det_ack;
  assign a_ready     = !a_valid || b_ready;
  // the q path sees the same acks, so both readies move in lockstep.
  assign setup_ready = a_ready;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      a_valid   <= 1'b0;
      det_valid <= 1'b0;
    end else begin
      if (a_ready) begin
        a_valid <= setup_valid;
      end
      if (b_ready) begin
        det_valid <= a_valid;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (setup_valid && a_ready) begin
      a_p   <= cross3(widen3(setup.dir), setup.e2); // P = D x E2.
      a_e1  <= setup.e1;
      a_t   <= setup.t;
      a_ids <= setup.ids;
    end
  end

  always_ff @(posedge clk) begin
    if (a_valid && b_ready) begin
      det_res.det   <= dot3(a_e1, a_p);
      det_res.u_pre <= dot3(a_t, a_p); // still scaled by det.
      det_res.ids   <= a_ids;
    end
  end

endmodule

/* src/q_path.sv */
`timescale 1ns/100ps

module q_path (
  input  logic           clk,
  input  logic           rst,
  input  rt_pkg::setup_t setup,
  input  logic           setup_valid,
  output logic           setup_ready,
  output rt_pkg::q_res_t q_res,
  output logic           q_valid,
  input  logic           q_ack
);
  import rt_pkg::*;

  logic    a_valid;
  logic    a_ready;
  logic    b_ready;
  cross3_t a_q;
  vec3_t   a_dir;
  edge3_t  a_e2;

  assign b_ready     = !q_valid || q_ack;
  assign a_ready     = !a_valid || b_ready;
  assign setup_ready = a_ready;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      a_valid <= 1'b0;
      q_valid <= 1'b0;
    end else begin
      if (a_ready) begin
        a_valid <= setup_valid;
      end
      if (b_ready) begin
        q_valid <= a_valid;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (setup_valid && a_ready) begin
      a_q   <= cross3(setup.t, setup.e1); // Q = T x E1.
      a_dir <= setup.dir;
      a_e2  <= setup.e2;
    end
  end

  // ids ride along the det path, so this side carries only the sums.
  always_ff @(posedge clk) begin
    if (a_valid && b_ready) begin
      q_res.v_pre <= dot3(widen3(a_dir), a_q);
      q_res.t_pre <= dot3(a_e2, a_q);
    end
  end

endmodule

/* src/stage3_join.sv */
`timescale 1ns/100ps

module stage3_join (
  input  logic             clk,
  input  logic             rst,
  input  rt_pkg::det_res_t det_res,
  input  logic             det_valid,
  input  rt_pkg::q_res_t   q_res,
  input  logic             q_valid,
  output logic             det_ack,
  output logic             q_ack,
  output rt_pkg::stage3_t  s3,
  output logic             s3_valid,
  input  logic             s3_ready
);
  import rt_pkg::*;

  join_state_t state;
  join_state_t nxt_state;
  logic        ld;
  logic        free;

  // the holding register can take a new record if empty or draining.
  assign free = !s3_valid || s3_ready;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      state <= nxt_state;
    end
  end

  always_comb begin
    ld        = 1'b0;
    nxt_state = state;
    case (state)
      IDLE: begin
        if (det_valid && q_valid && free) begin
          ld        = 1'b1;
          nxt_state = ACK;
        end else if (det_valid) begin
          nxt_state = GOT_DET;
        end else if (q_valid) begin
          nxt_state = GOT_Q;
        end
      end
      GOT_DET: begin
        if (q_valid && free) begin
          ld        = 1'b1;
          nxt_state = ACK;
        end
      end
      GOT_Q: begin
        if (det_valid && free) begin
          ld        = 1'b1;
          nxt_state = ACK;
        end
      end
      ACK: begin
        nxt_state = IDLE; // both paths drain on this edge.
      end
    endcase
  end

  assign det_ack = (state == ACK);
  assign q_ack   = (state == ACK);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      s3_valid <= 1'b0;
    end else if (ld) begin
      s3_valid <= 1'b1;
    end else if (s3_ready) begin
      s3_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (ld) begin
      s3.det   <= det_res.det;
      s3.u_pre <= det_res.u_pre;
      s3.v_pre <= q_res.v_pre;
      s3.t_pre <= q_res.t_pre;
      s3.ids   <= det_res.ids;
    end
  end

endmodule

/* src/hit_decide.sv */
`timescale 1ns/100ps

module hit_decide #(
  parameter bit CULL_BACKFACE = 1'b1
) (
  input  logic                clk,
  input  logic                rst,
  input  rt_pkg::stage3_t     s3,
  input  logic                s3_valid,
  output logic                s3_ready,
  output rt_pkg::hit_result_t out,
  output logic                out_valid,
  input  logic                out_ready
);
  import rt_pkg::*;

  logic               flip;
  logic               hit;
  logic signed [33:0] d_n;
  logic signed [33:0] u_n;
  logic signed [33:0] v_n;
  logic signed [33:0] t_n;

  // without culling a negative det is folded onto the front-facing case.
  assign flip = !CULL_BACKFACE && (s3.det < 0);

  always_comb begin
    d_n = flip ? -34'(s3.det) : 34'(s3.det);
    u_n = flip ? -34'(s3.u_pre) : 34'(s3.u_pre);
    v_n = flip ? -34'(s3.v_pre) : 34'(s3.v_pre);
    t_n = flip ? -34'(s3.t_pre) : 34'(s3.t_pre);
    hit = (d_n > 0) && (u_n >= 0) && (v_n >= 0) && (u_n + v_n <= d_n) && (t_n > 0);
  end

  assign s3_ready = !out_valid || out_ready;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (s3_ready) begin
      out_valid <= s3_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (s3_valid && s3_ready) begin
      out.ids   <= s3.ids;
      out.hit   <= hit;
      out.det   <= s3.det; // the caller divides t_pre by det itself.
      out.t_pre <= s3.t_pre;
    end
  end

endmodule

/* src/ray_tri_top.sv */
`timescale 1ns/100ps

module ray_tri_top #(
  parameter bit CULL_BACKFACE = 1'b1
) (
  input  logic                clk,
  input  logic                rst,
  input  rt_pkg::ray_tri_t    in,
  input  logic                in_valid,
  output logic                in_ready,
  output rt_pkg::hit_result_t out,
  output logic                out_valid,
  input  logic                out_ready
);
  import rt_pkg::*;

  setup_t   setup;
  logic     setup_valid;
  logic     det_ready;
  logic     q_ready;
  det_res_t det_res;
  logic     det_valid;
  q_res_t   q_res;
  logic     q_valid;
  logic     det_ack;
  logic     q_ack;
  stage3_t  s3;
  logic     s3_valid;
  logic     s3_ready;

  edge_setup u_edge_setup (
    .clk         (clk),
    .rst         (rst),
    .in          (in),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .setup       (setup),
    .setup_valid (setup_valid),
    .det_ready   (det_ready),
    .q_ready     (q_ready)
  );

  det_path u_det_path (
    .clk         (clk),
    .rst         (rst),
    .setup       (setup),
    .setup_valid (setup_valid),
    .setup_ready (det_ready),
    .det_res     (det_res),
    .det_valid   (det_valid),
    .det_ack     (det_ack)
  );

  q_path u_q_path (
    .clk         (clk),
    .rst         (rst),
    .setup       (setup),
    .setup_valid (setup_valid),
    .setup_ready (q_ready),
    .q_res       (q_res),
    .q_valid     (q_valid),
    .q_ack       (q_ack)
  );

  stage3_join u_stage3_join (
    .clk       (clk),
    .rst       (rst),
    .det_res   (det_res),
    .det_valid (det_valid),
    .q_res     (q_res),
    .q_valid   (q_valid),
    .det_ack   (det_ack),
    .q_ack     (q_ack),
    .s3        (s3),
    .s3_valid  (s3_valid),
    .s3_ready  (s3_ready)
  );

  hit_decide #(
    .CULL_BACKFACE (CULL_BACKFACE)
  ) u_hit_decide (
    .clk       (clk),
    .rst       (rst),
    .s3        (s3),
    .s3_valid  (s3_valid),
    .s3_ready  (s3_ready),
    .out       (out),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

endmodule

/* tb/ray_tri_model.svh */
`ifndef RAY_TRI_MODEL_SVH
`define RAY_TRI_MODEL_SVH

function automatic longint coord(input logic signed [COORD_W-1:0] c);
  return longint'(c);
endfunction

// one component of a x b, given the two other components of each vector.
function automatic longint cross_term(input longint a1, input longint a2,
                                      input longint b1, input longint b2);
  return a1 * b2 - a2 * b1;
endfunction

// Moller-Trumbore sums without the final division by det.
function automatic void compute_sums(input ray_tri_t r, output longint det, output longint u,
                                     output longint v, output longint t);
  longint dx, dy, dz;
  longint e1x, e1y, e1z;
  longint e2x, e2y, e2z;
  longint tx, ty, tz;
  longint px, py, pz;
  longint qx, qy, qz;
  dx  = coord(r.dir.x);
  dy  = coord(r.dir.y);
  dz  = coord(r.dir.z);
  e1x = coord(r.v1.x) - coord(r.v0.x);
  e1y = coord(r.v1.y) - coord(r.v0.y);
  e1z = coord(r.v1.z) - coord(r.v0.z);
  e2x = coord(r.v2.x) - coord(r.v0.x);
  e2y = coord(r.v2.y) - coord(r.v0.y);
  e2z = coord(r.v2.z) - coord(r.v0.z);
  tx  = coord(r.orig.x) - coord(r.v0.x);
  ty  = coord(r.orig.y) - coord(r.v0.y);
  tz  = coord(r.orig.z) - coord(r.v0.z);
  px  = cross_term(dy, dz, e2y, e2z);
  py  = cross_term(dz, dx, e2z, e2x);
  pz  = cross_term(dx, dy, e2x, e2y);
  qx  = cross_term(ty, tz, e1y, e1z);
  qy  = cross_term(tz, tx, e1z, e1x);
  qz  = cross_term(tx, ty, e1x, e1y);
  det = e1x * px + e1y * py + e1z * pz;
  u   = tx * px + ty * py + tz * pz;
  v   = dx * qx + dy * qy + dz * qz;
  t   = e2x * qx + e2y * qy + e2z * qz;
endfunction

function automatic hit_result_t expected_result(input ray_tri_t r);
  hit_result_t res;
  longint det, u, v, t;
  compute_sums(r, det, u, v, t);
  res.ids   = r.ids;
  res.det   = DOT_W'(det);
  res.t_pre = DOT_W'(t);
  res.hit   = (det > 0) && (u >= 0) && (v >= 0) && (u + v <= det) && (t > 0); // culling on.
  return res;
endfunction

`endif

/* tb/ray_tri_tb.sv */
`timescale 1ns/100ps

module ray_tri_tb;
  import rt_pkg::*;

  `include "ray_tri_model.svh"

  localparam int N_STREAM   = 200;
  localparam int MAX_CYCLES = 250 * 12 + 200; // worst case per item plus reset and drain.
  localparam int SEED       = 89;

  logic        clk;
  logic        rst;
  ray_tri_t    in;
  logic        in_valid;
  logic        in_ready;
  hit_result_t out;
  logic        out_valid;
  logic        out_ready = 1'b1;

  hit_result_t exp_q[$];
  hit_result_t want_out;
  hit_result_t stall_out;
  ray_tri_t    stream[N_STREAM];
  logic        ready_pat[256];
  logic        stall_pending = 1'b0;
  logic        bp_on = 1'b0;
  int          bp_idx = 0;
  int          cycle_count = 0;

  ray_tri_top #(
    .CULL_BACKFACE (1'b1)
  ) UUT (
    .clk       (clk),
    .rst       (rst),
    .in        (in),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out       (out),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic stop_with_failure();
    $display("Test failures found");
    $fatal(1, "stopping at the first failure");
  endtask

  task automatic check_field(input string name, input logic [63:0] got,
                             input logic [63:0] want);
    assert (got === want) else begin
      $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, want);
      stop_with_failure();
    end
  endtask

  function automatic int rnd_range(input int lo, input int hi);
    return lo + int'($urandom_range(32'(hi - lo)));
  endfunction

  function automatic vec3_t vec(input int x, input int y, input int z);
    vec3_t r;
    r.x = COORD_W'(x);
    r.y = COORD_W'(y);
    r.z = COORD_W'(z);
    return r;
  endfunction

  function automatic ray_tri_t make_request(input vec3_t orig, input vec3_t dir, input vec3_t v0,
                                            input vec3_t v1, input vec3_t v2, input int tag);
    ray_tri_t r;
    r.orig          = orig;
    r.dir           = dir;
    r.v0            = v0;
    r.v1            = v1;
    r.v2            = v2;
    r.ids.tri_id    = TRI_ID_W'(tag * 37);
    r.ids.thread_id = THREAD_W'(tag);
    r.ids.sid       = 32'h5a00_0000 + 32'(tag);
    return r;
  endfunction

  // half of the rays aim near the centroid so that hits are common.
  function automatic ray_tri_t random_request();
    ray_tri_t r;
    int cx;
    int cy;
    int cz;
    r.v0   = vec(rnd_range(-60, 60), rnd_range(-60, 60), rnd_range(-60, 60));
    r.v1   = vec(rnd_range(-60, 60), rnd_range(-60, 60), rnd_range(-60, 60));
    r.v2   = vec(rnd_range(-60, 60), rnd_range(-60, 60), rnd_range(-60, 60));
    r.orig = vec(rnd_range(-60, 60), rnd_range(-60, 60), rnd_range(-60, 60));
    cx = (int'(r.v0.x) + int'(r.v1.x) + int'(r.v2.x)) / 3;
    cy = (int'(r.v0.y) + int'(r.v1.y) + int'(r.v2.y)) / 3;
    cz = (int'(r.v0.z) + int'(r.v1.z) + int'(r.v2.z)) / 3;
    if ($urandom_range(1) == 0) begin
      r.dir = vec(rnd_range(-128, 127), rnd_range(-128, 127), rnd_range(-128, 127));
    end else begin
      r.dir = vec(cx - int'(r.orig.x) + rnd_range(-7, 7), cy - int'(r.orig.y) + rnd_range(-7, 7),
                  cz - int'(r.orig.z) + rnd_range(-7, 7));
    end
    r.ids.tri_id    = TRI_ID_W'($urandom);
    r.ids.thread_id = THREAD_W'($urandom);
    r.ids.sid       = $urandom;
    return r;
  endfunction

  // called on a falling edge and returns on the falling edge after the transfer.
  task automatic send_request(input ray_tri_t r);
    logic accepted;
    in       = r;
    in_valid = 1'b1;
    do begin
      accepted = in_ready; // in_ready does not depend on in_valid.
      @(negedge clk);
    end while (!accepted);
    exp_q.push_back(expected_result(r));
    in_valid = 1'b0;
  endtask

  task automatic wait_for_results();
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
  endtask

  task automatic run_directed(input ray_tri_t r, input logic want_hit);
    hit_result_t exp;
    exp = expected_result(r);
    assert (exp.hit == want_hit) else begin
      $display("directed vector with sid 0x%0h misses its intended case", r.ids.sid);
      stop_with_failure();
    end
    send_request(r);
    wait_for_results();
  endtask

  always @(negedge clk) begin
    if (bp_on) begin
      out_ready = ready_pat[bp_idx];
      bp_idx    = (bp_idx + 1) % 256;
    end else begin
      out_ready = 1'b1;
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout after %0d cycles, %0d results outstanding", cycle_count, exp_q.size());
      stop_with_failure();
    end
  end

  always @(posedge clk) begin
    if (!rst) begin
      if (stall_pending) begin
        assert (out_valid) else begin
          $display("out_valid dropped while out_ready was low");
          stop_with_failure();
        end
        assert (out === stall_out) else begin
          $display("** Error: out = 0x%h, expected held 0x%h", out, stall_out);
          stop_with_failure();
        end
      end
      stall_pending = out_valid && !out_ready;
      stall_out     = out;
      if (out_valid && out_ready) begin
        assert (exp_q.size() != 0) else begin
          $display("result with sid 0x%0h arrived with no request outstanding", out.ids.sid);
          stop_with_failure();
        end
        want_out = exp_q.pop_front();
        check_field("out.ids.tri_id", 64'(out.ids.tri_id), 64'(want_out.ids.tri_id));
        check_field("out.ids.thread_id", 64'(out.ids.thread_id), 64'(want_out.ids.thread_id));
        check_field("out.ids.sid", 64'(out.ids.sid), 64'(want_out.ids.sid));
        check_field("out.hit", 64'(out.hit), 64'(want_out.hit));
        check_field("out.det", 64'(out.det), 64'(want_out.det));
        check_field("out.t_pre", 64'(out.t_pre), 64'(want_out.t_pre));
      end
    end
  end

  initial begin
    vec3_t v0;
    vec3_t v1;
    vec3_t v2;
    vec3_t dz;
    void'($urandom(SEED));
    rst      = 1'b1;
    in       = '0;
    in_valid = 1'b0;
    repeat (8) begin
      @(negedge clk);
      assert (out_valid === 1'b0) else begin
        $display("** Error: out_valid = 0x%h during reset, expected 0x0", out_valid);
        stop_with_failure();
      end
    end
    rst = 1'b0;
    @(negedge clk);
    assert (out_valid === 1'b0) else begin
      $display("** Error: out_valid = 0x%h after reset, expected 0x0", out_valid);
      stop_with_failure();
    end

    // front-facing triangle in the plane z = 10, ray along +z.
    v0 = vec(0, 0, 10);
    v1 = vec(0, 20, 10);
    v2 = vec(20, 0, 10);
    dz = vec(0, 0, 1);
    run_directed(make_request(vec(5, 5, 0), dz, v0, v1, v2, 1), 1'b1);
    run_directed(make_request(vec(10, 10, 0), dz, v0, v1, v2, 2), 1'b1); // u + v equals det.
    run_directed(make_request(vec(5, -5, 0), dz, v0, v1, v2, 3), 1'b0);
    run_directed(make_request(vec(-5, 5, 0), dz, v0, v1, v2, 4), 1'b0);
    run_directed(make_request(vec(15, 15, 0), dz, v0, v1, v2, 5), 1'b0);
    run_directed(make_request(vec(5, 5, 20), dz, v0, v1, v2, 6), 1'b0);
    run_directed(make_request(vec(5, 5, 10), dz, v0, v1, v2, 7), 1'b0); // t_pre is zero.
    run_directed(make_request(vec(5, 5, 0), dz, v0, v2, v1, 8), 1'b0);  // wound backwards.

    for (int i = 0; i < N_STREAM; i++) begin
      stream[i] = random_request();
    end
    for (int i = 0; i < 256; i++) begin
      ready_pat[i] = ($urandom_range(9) < 6);
    end

    for (int i = 0; i < N_STREAM; i++) begin
      send_request(stream[i]);
    end
    wait_for_results();

    @(posedge clk);
    bp_on = 1'b1;
    @(negedge clk);
    for (int i = 0; i < N_STREAM; i++) begin
      repeat (rnd_range(0, 3)) @(negedge clk);
      send_request(stream[i]);
    end
    wait_for_results();
    @(posedge clk);
    bp_on = 1'b0;

    repeat (20) @(negedge clk); // any extra result shows up here.
    $display("All tests passed!");
    $finish;
  end

endmodule

/* ray_tri_top.f */
+incdir+tb
src/rt_pkg.sv
src/edge_setup.sv
src/det_path.sv
src/q_path.sv
src/stage3_join.sv
src/hit_decide.sv
src/ray_tri_top.sv
tb/ray_tri_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the ray/triangle testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f ray_tri_top.f \
  --top-module ray_tri_tb -o ray_tri_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/ray_tri_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Test failures found" "$LOG"; then
  echo "simulation reported failures, see $LOG"
  exit 1
fi

if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

exit 0
